// ==== source/trigger_chain_pkg.sv ====
`default_nettype none

package trigger_chain_pkg;

    //////////////////////////////
    // Widths and lane counts
    localparam int SAMPLE_BITS = 12;
    localparam int OUT_BITS    = 5;
    localparam int NSAMP_IN    = 8;   // Lanes per cycle at input and output
    localparam int NSAMP_MID   = 4;   // Lanes after pair averaging

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef sample_t [NSAMP_IN-1:0]        in_block_t;
    typedef sample_t [NSAMP_MID-1:0]       mid_block_t;
    typedef logic signed [OUT_BITS-1:0]    out_sample_t;
    typedef out_sample_t [NSAMP_IN-1:0]    out_block_t;

    typedef struct packed {
        logic [16:0]        scale;   // Unsigned, SCALE_FRAC_BITS fraction bits
        logic signed [15:0] offset;
    } agc_gain_t;

    typedef struct packed {
        logic [24:0] mean_sq;
        logic [15:0] n_pos;
        logic [15:0] n_neg;
    } agc_stats_t;

    //////////////////////////////
    // Fixed AGC constants
    localparam logic [16:0]        START_SCALE  = 17'd1500;
    localparam logic signed [15:0] START_OFFSET = 16'sd0;
    localparam int SCALE_MIN       = 300;
    localparam int SCALE_MAX       = 130000;
    localparam int OFFSET_LIMIT    = 1000;
    localparam int SCALE_FRAC_BITS = 12;
    localparam int OFFSET_SHIFT    = 4;
    localparam int OUT_MIN         = -16;
    localparam int OUT_MAX         = 15;

    // Floor average of two samples, sum kept one bit wider
    function automatic sample_t pair_avg(sample_t a, sample_t b);
        logic signed [SAMPLE_BITS:0] sum;
        sum = {a[SAMPLE_BITS-1], a} + {b[SAMPLE_BITS-1], b};
        return sample_t'(sum >>> 1);
    endfunction

endpackage

`default_nettype wire

// ==== source/sample_decimator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_decimator import trigger_chain_pkg::*; (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  in_block_t  dat_i,
    output mid_block_t dat_o
);

    mid_block_t avg;

    // Each adjacent pair collapses to one lane
    always_comb begin
        for (int k = 0; k < NSAMP_MID; k++) begin
            avg[k] = pair_avg(dat_i[2*k], dat_i[2*k+1]);
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            dat_o <= '0;   // Zeros flow out during reset
        end else begin
            dat_o <= avg;
        end
    end

endmodule

`default_nettype wire

// ==== source/sample_interpolator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_interpolator import trigger_chain_pkg::*; (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  mid_block_t dat_i,
    output in_block_t  dat_o
);

    in_block_t interp;

    //////////////////////////////
    // Even lanes copy, odd lanes average neighbours
    always_comb begin
        for (int k = 0; k < NSAMP_MID; k++) begin
            interp[2*k] = dat_i[k];
        end
        for (int k = 0; k < NSAMP_MID - 1; k++) begin
            interp[2*k+1] = pair_avg(dat_i[k], dat_i[k+1]);
        end
        // No lane k+1 inside this block for the last one
        interp[NSAMP_IN-1] = dat_i[NSAMP_MID-1];
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            dat_o <= '0;
        end else begin
            dat_o <= interp;
        end
    end

endmodule

`default_nettype wire

// ==== source/agc_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_scaler import trigger_chain_pkg::*; (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  in_block_t  dat_i,
    input  agc_gain_t  gain_i,
    output out_block_t dat_o
);

    localparam int PROD_BITS = 32;   // 12x18 product plus shifted offset

    logic signed [PROD_BITS-1:0] offs_term;
    logic signed [PROD_BITS-1:0] scaled [NSAMP_IN];
    out_block_t                  sat;

    always_comb begin
        offs_term = PROD_BITS'(gain_i.offset) <<< OFFSET_SHIFT;
        for (int i = 0; i < NSAMP_IN; i++) begin
            // Scale is unsigned, widen with a zero so the multiply stays signed
            scaled[i] = ($signed(dat_i[i]) * $signed({1'b0, gain_i.scale}) + offs_term)
                        >>> SCALE_FRAC_BITS;
            if (scaled[i] > OUT_MAX) begin
                sat[i] = out_sample_t'(OUT_MAX);
            end else if (scaled[i] < OUT_MIN) begin
                sat[i] = out_sample_t'(OUT_MIN);
            end else begin
                sat[i] = scaled[i][OUT_BITS-1:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            dat_o <= '0;
        end else begin
            dat_o <= sat;
        end
    end

    // Clamping rather than wrapping keeps the lane order
    for (genvar g = 0; g < NSAMP_IN - 1; g++) begin : g_sat_chk
        assert property (@(posedge aclk) disable iff (wb_rst_i)
            ($signed(dat_i[g]) >= $signed(dat_i[g+1]))
            |=> ($signed(dat_o[g]) >= $signed(dat_o[g+1])));
        assert property (@(posedge aclk) disable iff (wb_rst_i)
            ($signed(dat_i[g]) <= $signed(dat_i[g+1]))
            |=> ($signed(dat_o[g]) <= $signed(dat_o[g+1])));
    end

endmodule

`default_nettype wire

// ==== source/agc_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_monitor import trigger_chain_pkg::*; #(
    parameter int WINDOW_BITS = 4
) (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  wire        agc_reset_i,
    input  out_block_t dat_i,
    output agc_stats_t stats_o,
    output logic       stats_valid_o
);

    localparam int SUM_BITS = 12 + WINDOW_BITS;   // 8 lanes of at most 256 per block

    logic [WINDOW_BITS-1:0] blk_cnt;
    logic                   last_blk;
    logic [SUM_BITS-1:0]    sq_sum, sq_next;
    logic [15:0]            pos_cnt, neg_cnt, pos_next, neg_next;
    logic [11:0]            blk_sq;
    logic [3:0]             blk_pos, blk_neg;

    //////////////////////////////
    // Per-block square sum and sign counts
    always_comb begin
        logic signed [9:0] lane_sq;
        blk_sq  = '0;
        blk_pos = '0;
        blk_neg = '0;
        for (int i = 0; i < NSAMP_IN; i++) begin
            lane_sq = $signed(dat_i[i]) * $signed(dat_i[i]);
            blk_sq  = blk_sq + 12'(lane_sq);
            if ($signed(dat_i[i]) > 0) blk_pos = blk_pos + 1'b1;
            if ($signed(dat_i[i]) < 0) blk_neg = blk_neg + 1'b1;
        end
    end

    assign last_blk = (blk_cnt == '1);
    assign sq_next  = sq_sum + SUM_BITS'(blk_sq);
    assign pos_next = pos_cnt + 16'(blk_pos);
    assign neg_next = neg_cnt + 16'(blk_neg);

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            blk_cnt       <= '0;
            sq_sum        <= '0;
            pos_cnt       <= '0;
            neg_cnt       <= '0;
            stats_valid_o <= 1'b0;
        end else begin
            blk_cnt       <= blk_cnt + 1'b1;   // Wraps into the next window
            stats_valid_o <= last_blk;
            sq_sum        <= last_blk ? '0 : sq_next;
            pos_cnt       <= last_blk ? '0 : pos_next;
            neg_cnt       <= last_blk ? '0 : neg_next;
        end
    end

    // Window totals include the block absorbed on this edge
    always_ff @(posedge aclk) begin
        if (last_blk) begin
            stats_o.mean_sq <= 25'(sq_next >> (WINDOW_BITS + 3));
            stats_o.n_pos   <= pos_next;
            stats_o.n_neg   <= neg_next;
        end
    end

    assert property (@(posedge aclk) disable iff (wb_rst_i)
        stats_valid_o |=> !stats_valid_o);

endmodule

`default_nettype wire

// ==== source/agc_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_loop import trigger_chain_pkg::*; #(
    parameter int TARGET_RMS_SQUARED   = 16,
    parameter int RMS_SQUARE_SCALE_ERR = 0,
    parameter int OFFSET_ERR           = 5,
    parameter int SCALE_DELTA          = 30,
    parameter int OFFSET_DELTA         = 25
) (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  wire        agc_reset_i,
    input  wire        agc_en_i,
    input  agc_stats_t stats_i,
    input  wire        stats_valid_i,
    output agc_gain_t  gain_o,
    output logic       update_o
);

    localparam int                 SQ_HIGH     = TARGET_RMS_SQUARED + RMS_SQUARE_SCALE_ERR;
    localparam int                 SQ_LOW      = TARGET_RMS_SQUARED - RMS_SQUARE_SCALE_ERR;
    localparam logic [16:0]        SCALE_STEP  = 17'(SCALE_DELTA);
    localparam logic signed [15:0] OFFSET_STEP = 16'(OFFSET_DELTA);

    agc_gain_t gain_next;
    logic      do_update;

    assign do_update = stats_valid_i && agc_en_i;

    //////////////////////////////
    // Step rules, each value holds unless a rule fires
    always_comb begin
        gain_next = gain_o;

        // Scale follows the mean square
        if (int'(stats_i.mean_sq) > SQ_HIGH) begin
            if (gain_o.scale > SCALE_MIN) gain_next.scale = gain_o.scale - SCALE_STEP;
        end else if (int'(stats_i.mean_sq) < SQ_LOW) begin
            if (gain_o.scale < SCALE_MAX) gain_next.scale = gain_o.scale + SCALE_STEP;
        end

        // Offset pushes against the dominant sign
        if (int'(stats_i.n_pos) > int'(stats_i.n_neg) + OFFSET_ERR) begin
            if ($signed(gain_o.offset) > -OFFSET_LIMIT) begin
                gain_next.offset = gain_o.offset - OFFSET_STEP;
            end
        end else if (int'(stats_i.n_neg) > int'(stats_i.n_pos) + OFFSET_ERR) begin
            if ($signed(gain_o.offset) < OFFSET_LIMIT) begin
                gain_next.offset = gain_o.offset + OFFSET_STEP;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            gain_o   <= '{scale: START_SCALE, offset: START_OFFSET};
            update_o <= 1'b0;
        end else begin
            update_o <= do_update;   // High while the new gain is first visible
            if (do_update) gain_o <= gain_next;
        end
    end

    assert property (@(posedge aclk) disable iff (wb_rst_i)
        update_o |-> $past(stats_valid_i));

    // Gain frozen while the loop is off
    assert property (@(posedge aclk) disable iff (wb_rst_i)
        (!agc_en_i && !agc_reset_i) |=> $stable(gain_o));

endmodule

`default_nettype wire

// ==== source/trigger_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_chain import trigger_chain_pkg::*; #(
    parameter int WINDOW_BITS          = 4,
    parameter int TARGET_RMS_SQUARED   = 16,
    parameter int RMS_SQUARE_SCALE_ERR = 0,
    parameter int OFFSET_ERR           = 5,
    parameter int SCALE_DELTA          = 30,
    parameter int OFFSET_DELTA         = 25
) (
    input  wire        aclk,
    input  wire        wb_rst_i,
    input  wire        agc_reset_i,
    input  wire        agc_en_i,
    input  in_block_t  dat_i,
    output out_block_t dat_o,
    output agc_gain_t  agc_gain_o,
    output logic       agc_update_o
);

    mid_block_t mid_blk;      // Half rate lanes
    in_block_t  interp_blk;
    agc_stats_t stats;
    logic       stats_valid;

    //////////////////////////////
    // Data path, one register per stage
    sample_decimator u_decimator (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (dat_i),
        .dat_o    (mid_blk)
    );

    sample_interpolator u_interpolator (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (mid_blk),
        .dat_o    (interp_blk)
    );

    agc_scaler u_scaler (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .dat_i    (interp_blk),
        .gain_i   (agc_gain_o),
        .dat_o    (dat_o)
    );

    //////////////////////////////
    // Gain control loop on the 5-bit output
    agc_monitor #(.WINDOW_BITS(WINDOW_BITS)) u_monitor (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_reset_i   (agc_reset_i),
        .dat_i         (dat_o),
        .stats_o       (stats),
        .stats_valid_o (stats_valid)
    );

    agc_loop #(
        .TARGET_RMS_SQUARED   (TARGET_RMS_SQUARED),
        .RMS_SQUARE_SCALE_ERR (RMS_SQUARE_SCALE_ERR),
        .OFFSET_ERR           (OFFSET_ERR),
        .SCALE_DELTA          (SCALE_DELTA),
        .OFFSET_DELTA         (OFFSET_DELTA)
    ) u_loop (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_reset_i   (agc_reset_i),
        .agc_en_i      (agc_en_i),
        .stats_i       (stats),
        .stats_valid_i (stats_valid),
        .gain_o        (agc_gain_o),
        .update_o      (agc_update_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk_o
);

    // Free running, first rising edge half a period in
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_trigger_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_trigger_chain import trigger_chain_pkg::*; ();

    localparam int WINDOW_BITS    = 4;
    localparam int TARGET_SQ      = 16;
    localparam int SQ_ERR         = 0;
    localparam int OFFSET_ERR     = 5;
    localparam int SCALE_DELTA    = 30;
    localparam int OFFSET_DELTA   = 25;
    localparam int WIN_LEN        = 1 << WINDOW_BITS;
    localparam int TIMEOUT_CYCLES = 400 + 800 + 800 + 400 + 200 + 100 + 100;

    wire        aclk;
    logic       wb_rst;
    logic       agc_rst;
    logic       agc_en;
    in_block_t  din;
    out_block_t dout;
    agc_gain_t  gain;
    logic       upd;

    logic [31:0] seed = 32'h6427_96e1;
    int n_checks  = 0;
    int n_errors  = 0;
    int cycle_cnt = 0;

    // Reference model, one variable per DUT register
    int m_mid [NSAMP_MID];
    int m_itp [NSAMP_IN];
    int m_out [NSAMP_IN];
    int m_scale, m_off;
    int m_cnt, m_sq, m_pos, m_neg;    // Running window sums
    int m_msq, m_npos, m_nneg;        // Registered statistics
    bit m_upd, m_sv;

    tb_clock_gen #(.PERIOD_NS(8.0)) u_clock_gen (.clk_o(aclk));

    trigger_chain #(
        .WINDOW_BITS          (WINDOW_BITS),
        .TARGET_RMS_SQUARED   (TARGET_SQ),
        .RMS_SQUARE_SCALE_ERR (SQ_ERR),
        .OFFSET_ERR           (OFFSET_ERR),
        .SCALE_DELTA          (SCALE_DELTA),
        .OFFSET_DELTA         (OFFSET_DELTA)
    ) u_trigger_chain (
        .aclk         (aclk),
        .wb_rst_i     (wb_rst),
        .agc_reset_i  (agc_rst),
        .agc_en_i     (agc_en),
        .dat_i        (din),
        .dat_o        (dout),
        .agc_gain_o   (gain),
        .agc_update_o (upd)
    );

    //////////////////////////////
    // Stimulus helpers
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_sample(int amp, int bias);
        int v;
        seed = lcg_next(seed);
        v = int'(seed[30:16]) % (2 * amp + 1) - amp + bias;
        if (v > 2047) v = 2047;       // Clip to the 12-bit range
        if (v < -2048) v = -2048;
        return v;
    endfunction

    task automatic drive_block(int amp, int bias);
        for (int k = 0; k < NSAMP_IN; k++) begin
            din[k] = sample_t'(rand_sample(amp, bias));
        end
    endtask

    task automatic check(string name, logic [63:0] expv, logic [63:0] actv);
        n_checks++;
        if (actv !== expv) begin
            n_errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expv, actv);
        end
    endtask

    //////////////////////////////
    // Model update for one rising edge, last stage first
    task automatic model_step();
        int ns, no, bsq, bp, bn, v;
        if (wb_rst) begin
            m_mid   = '{default: 0};
            m_itp   = '{default: 0};
            m_out   = '{default: 0};
            m_scale = START_SCALE;
            m_off   = START_OFFSET;
            m_upd   = 0;
            m_sv    = 0;
            m_cnt   = 0;
            m_sq    = 0;
            m_pos   = 0;
            m_neg   = 0;
        end else begin
            ns = m_scale;
            no = m_off;
            if (m_sv && agc_en) begin
                if (m_msq > TARGET_SQ + SQ_ERR) begin
                    if (m_scale > SCALE_MIN) ns = m_scale - SCALE_DELTA;
                end else if (m_msq < TARGET_SQ - SQ_ERR) begin
                    if (m_scale < SCALE_MAX) ns = m_scale + SCALE_DELTA;
                end
                if (m_npos > m_nneg + OFFSET_ERR) begin
                    if (m_off > -OFFSET_LIMIT) no = m_off - OFFSET_DELTA;
                end else if (m_nneg > m_npos + OFFSET_ERR) begin
                    if (m_off < OFFSET_LIMIT) no = m_off + OFFSET_DELTA;
                end
            end
            m_upd = m_sv && agc_en && !agc_rst;
            if (agc_rst) begin
                ns = START_SCALE;
                no = START_OFFSET;
            end
            bsq = 0;
            bp  = 0;
            bn  = 0;
            foreach (m_out[i]) begin
                bsq += m_out[i] * m_out[i];
                if (m_out[i] > 0) bp++;
                if (m_out[i] < 0) bn++;
            end
            m_sv = (m_cnt == WIN_LEN - 1);   // Window closes on this block
            if (m_sv) begin
                m_msq  = (m_sq + bsq) >> (WINDOW_BITS + 3);
                m_npos = m_pos + bp;
                m_nneg = m_neg + bn;
                m_sq   = 0;
                m_pos  = 0;
                m_neg  = 0;
            end else begin
                m_sq  += bsq;
                m_pos += bp;
                m_neg += bn;
            end
            m_cnt = (m_cnt + 1) % WIN_LEN;
            if (agc_rst) begin
                m_sv  = 0;
                m_cnt = 0;
                m_sq  = 0;
                m_pos = 0;
                m_neg = 0;
            end
            foreach (m_out[i]) begin
                v = (m_itp[i] * m_scale + m_off * 16) >>> SCALE_FRAC_BITS;
                m_out[i] = (v > OUT_MAX) ? OUT_MAX : ((v < OUT_MIN) ? OUT_MIN : v);
            end
            for (int k = 0; k < NSAMP_MID; k++) m_itp[2*k] = m_mid[k];
            for (int k = 0; k < NSAMP_MID - 1; k++) begin
                m_itp[2*k+1] = (m_mid[k] + m_mid[k+1]) >>> 1;
            end
            m_itp[NSAMP_IN-1] = m_mid[NSAMP_MID-1];
            for (int k = 0; k < NSAMP_MID; k++) begin
                m_mid[k] = (int'(din[2*k]) + int'(din[2*k+1])) >>> 1;
            end
            m_scale = ns;
            m_off   = no;
        end
    endtask

    task automatic compare_all(string name);
        out_block_t exp_blk;
        foreach (m_out[i]) exp_blk[i] = out_sample_t'(m_out[i]);
        check({name, "/dat_o"}, exp_blk, dout);
        check({name, "/scale"}, m_scale, gain.scale);
        check({name, "/offset"}, m_off[15:0], $unsigned(gain.offset));
        check({name, "/update"}, m_upd, upd);
    endtask

    // Outputs are checked 1 ns after the edge, then new inputs follow
    task automatic step_cycle(string name);
        @(posedge aclk);
        model_step();
        #1;
        compare_all(name);
    endtask

    task automatic run_phase(string name, int ncyc, int amp, int bias, output int first_upd);
        agc_gain_t held;
        held      = gain;
        first_upd = 0;
        for (int i = 1; i <= ncyc; i++) begin
            drive_block(amp, bias);
            step_cycle(name);
            if (upd && first_upd == 0) first_upd = i;
            if (!agc_en) begin
                check({name, "/held_gain"}, held, gain);
                check({name, "/no_update"}, 0, upd);
            end
        end
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        int first_upd;
        int off_start;
        wb_rst  = 1'b1;
        agc_rst = 1'b0;
        agc_en  = 1'b1;
        din     = '0;
        repeat (8) step_cycle("reset");
        check("reset/dat_o", 0, dout);
        check("reset/scale", START_SCALE, gain.scale);
        check("reset/offset", 0, $unsigned(gain.offset));
        check("reset/update", 0, upd);
        wb_rst = 1'b0;

        run_phase("moderate", 400, 128, 0, first_upd);
        run_phase("large", 800, 2047, 0, first_upd);
        check("large/scale_floor", SCALE_MIN, gain.scale);
        run_phase("small", 800, 8, 0, first_upd);
        check("small/scale_rise", 1, gain.scale > SCALE_MIN);
        off_start = $signed(gain.offset);
        run_phase("biased", 400, 64, 200, first_upd);   // Mostly positive output
        check("biased/offset_drop", 1, $signed(gain.offset) < off_start);

        agc_en = 1'b0;
        run_phase("agc_off", 200, 256, 0, first_upd);

        agc_en  = 1'b1;
        agc_rst = 1'b1;
        drive_block(128, 0);
        step_cycle("restart");
        check("restart/start_scale", START_SCALE, gain.scale);
        check("restart/start_offset", 0, $unsigned(gain.offset));
        agc_rst = 1'b0;
        // Full window, then the stats cycle, then the update
        run_phase("restart", 100, 128, 0, first_upd);
        check("restart/first_update", WIN_LEN + 1, first_upd);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/trigger_chain_pkg.sv
source/sample_decimator.sv
source/sample_interpolator.sv
source/agc_scaler.sv
source/agc_monitor.sv
source/agc_loop.sv
source/trigger_chain.sv
testbench/tb_clock_gen.sv
testbench/tb_trigger_chain.sv
